/* sram_params.svh */
// Sizing and timing of the two-chip SRAM subsystem.
// SRAM_SETUP and SRAM_STROBE count clock cycles and must both be at least 1.
`ifndef SRAM_PARAMS_SVH
`define SRAM_PARAMS_SVH

// Word address, one word spans both chips.
`define SRAM_AW 18

// Word data, chip 1 carries the upper half.
`define SRAM_DW 32

// Cycles with address and enables valid before the strobe falls.
`define SRAM_SETUP 1

// Strobe phase length. Read data is sampled at its last edge.
`define SRAM_STROBE 2

`endif

/* sram_pkg.sv */
// Shared types of the SRAM subsystem.
// Per-chip pin fields use index 1 for chip 1 (upper half) and 0 for chip 2.
`include "sram_params.svh"

package sram_pkg;

   // One word request as presented to the controller.
   typedef struct packed {
      logic [`SRAM_AW-1:0]   addr;
      logic                  we;    // 1 for a write.
      logic [`SRAM_DW/8-1:0] be;    // One bit per byte, bit 3 is the top byte.
      logic [`SRAM_DW-1:0]   wdata;
   } sram_req_t;

   // Board control pins, all strobes active low.
   typedef struct packed {
      logic [`SRAM_AW-1:0] a;
      logic                oe_n;
      logic                we_n;
      logic [1:0]          ce_n;
      logic [1:0]          ub_n;
      logic [1:0]          lb_n;
   } sram_pins_t;

endpackage

/* sram_chip.sv */
// Behavioral 256Kx16 asynchronous SRAM, for simulation only.
// No pin delays are modeled. A write lands at the rising edge of we_n.
// Reads ignore ce_n and depend on oe_n and the lane enables alone.
`timescale 1ns/1ps
`include "sram_params.svh"

module sram_chip (
   input  logic [`SRAM_AW-1:0] a,
   inout  wire  [15:0]         io,
   input  logic                ce_n,
   input  logic                ub_n,
   input  logic                lb_n,
   input  logic                we_n,
   input  logic                oe_n
);

   localparam int DEPTH = 1 << `SRAM_AW;

   logic [7:0] ram_h [DEPTH]; // Upper byte lane.
   logic [7:0] ram_l [DEPTH]; // Lower byte lane.

   logic rd_h;
   logic rd_l;

   // Each lane drives only while output enable and its own byte enable are low.
   assign rd_h = !oe_n && !ub_n;
   assign rd_l = !oe_n && !lb_n;

   assign io[15:8] = rd_h ? ram_h[a] : 8'bz;
   assign io[7:0]  = rd_l ? ram_l[a] : 8'bz;

   always @(posedge we_n)
   begin
      if (!ce_n)
      begin
         if (!ub_n)
         begin
            ram_h[a] <= io[15:8];
         end
         if (!lb_n)
         begin
            ram_l[a] <= io[7:0];
         end
      end
   end

endmodule

/* sram_board.sv */
// Two 256Kx16 chips wired as on the starter board.
// Address, we_n and oe_n are shared. Chip 1 holds bytes 3..2 of each word.
// Both chips are cleared to zero at time zero.
`timescale 1ns/1ps
`include "sram_params.svh"

module sram_board (
   input  sram_pkg::sram_pins_t pins,
   inout  wire  [15:0]          ram1_io,
   inout  wire  [15:0]          ram2_io
);

   sram_chip ram1 (
      .a    (pins.a),
      .io   (ram1_io),
      .ce_n (pins.ce_n[1]),
      .ub_n (pins.ub_n[1]),
      .lb_n (pins.lb_n[1]),
      .we_n (pins.we_n),
      .oe_n (pins.oe_n)
   );

   sram_chip ram2 (
      .a    (pins.a),
      .io   (ram2_io),
      .ce_n (pins.ce_n[0]),
      .ub_n (pins.ub_n[0]),
      .lb_n (pins.lb_n[0]),
      .we_n (pins.we_n),
      .oe_n (pins.oe_n)
   );

   // Start from a known all-zero memory image.
   initial
   begin
      for (int i = 0; i < (1 << `SRAM_AW); i++)
      begin
         ram1.ram_h[i] = 8'h00;
         ram1.ram_l[i] = 8'h00;
         ram2.ram_h[i] = 8'h00;
         ram2.ram_l[i] = 8'h00;
      end
   end

endmodule

/* sram_ctrl.sv */
// Word access controller for two 16-bit asynchronous SRAM chips.
// One access at a time. A req is taken only while busy is low.
// Done follows acceptance by SRAM_SETUP + SRAM_STROBE + 1 cycles.
`timescale 1ns/1ps
`include "sram_params.svh"

module sram_ctrl (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 req,
   input  sram_pkg::sram_req_t  req_data,
   output logic                 busy,
   output logic                 done,
   output logic [`SRAM_DW-1:0]  rdata,
   output sram_pkg::sram_pins_t pins,
   inout  wire  [15:0]          ram1_io,
   inout  wire  [15:0]          ram2_io
);

   localparam int CNT_MAX = (`SRAM_SETUP > `SRAM_STROBE) ? `SRAM_SETUP : `SRAM_STROBE;
   localparam int CNT_W   = $clog2(CNT_MAX) + 1;

   typedef enum logic [1:0] {IDLE, SETUP, STROBE, FINISH} state_t;

   state_t                state;
   logic [CNT_W-1:0]      cnt;
   logic                  accept;
   logic                  sample;
   logic                  drive;
   logic                  we_q;
   logic [`SRAM_DW/8-1:0] be_q;
   logic [`SRAM_DW-1:0]   wdata_q;
   logic [`SRAM_DW-1:0]   byte_mask;

   assign busy   = (state != IDLE);
   assign accept = req && !busy;
   assign sample = (state == STROBE) && (cnt == '0) && !we_q;

   assign byte_mask = {{8{be_q[3]}}, {8{be_q[2]}}, {8{be_q[1]}}, {8{be_q[0]}}};

   // Write data stays on the buses through the rising edge of we_n.
   assign ram1_io = drive ? wdata_q[31:16] : 16'bz;
   assign ram2_io = drive ? wdata_q[15:0]  : 16'bz;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state     <= IDLE;
         cnt       <= '0;
         done      <= 1'b0;
         drive     <= 1'b0;
         pins.a    <= '0;
         pins.oe_n <= 1'b1;
         pins.we_n <= 1'b1;
         pins.ce_n <= 2'b11;
         pins.ub_n <= 2'b11;
         pins.lb_n <= 2'b11;
      end
      else
      begin
         done <= 1'b0;
         case (state)
            IDLE:
            begin
               if (accept)
               begin
                  state     <= SETUP;
                  cnt       <= CNT_W'(`SRAM_SETUP - 1);
                  drive     <= req_data.we;
                  pins.a    <= req_data.addr;
                  pins.ce_n <= {~|req_data.be[3:2], ~|req_data.be[1:0]}; // Idle chips stay off.
                  pins.ub_n <= {~req_data.be[3], ~req_data.be[1]};
                  pins.lb_n <= {~req_data.be[2], ~req_data.be[0]};
               end
               else
               begin
                  drive     <= 1'b0; // Release the previous access one cycle after done.
                  pins.ce_n <= 2'b11;
                  pins.ub_n <= 2'b11;
                  pins.lb_n <= 2'b11;
               end
            end
            SETUP:
            begin
               if (cnt == '0)
               begin
                  state     <= STROBE;
                  cnt       <= CNT_W'(`SRAM_STROBE - 1);
                  pins.we_n <= !we_q;
                  pins.oe_n <= we_q;
               end
               else
               begin
                  cnt <= cnt - 1'b1;
               end
            end
            STROBE:
            begin
               if (cnt == '0)
               begin
                  state <= FINISH;
               end
               else
               begin
                  cnt <= cnt - 1'b1;
               end
            end
            FINISH:
            begin
               state     <= IDLE;
               done      <= 1'b1;
               pins.we_n <= 1'b1; // The chips store the write on this edge.
               pins.oe_n <= 1'b1;
            end
            default:
            begin
               state <= IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         we_q    <= req_data.we;
         be_q    <= req_data.be;
         wdata_q <= req_data.wdata;
      end
      if (sample)
      begin
         rdata <= {ram1_io, ram2_io} & byte_mask; // Disabled bytes read as zero.
      end
   end

endmodule

/* sram_sys.sv */
// Controller and two-chip board model joined over the pin struct.
// The board model clears its memory at start, so reads begin at zero.
`timescale 1ns/1ps
`include "sram_params.svh"

module sram_sys (
   input  logic                clk,
   input  logic                rst,
   input  logic                req,
   input  sram_pkg::sram_req_t req_data,
   output logic                busy,
   output logic                done,
   output logic [`SRAM_DW-1:0] rdata
);

   sram_pkg::sram_pins_t pins;
   wire [15:0]           ram1_io;
   wire [15:0]           ram2_io;

   sram_ctrl sram_ctrl_inst (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .req_data (req_data),
      .busy     (busy),
      .done     (done),
      .rdata    (rdata),
      .pins     (pins),
      .ram1_io  (ram1_io),
      .ram2_io  (ram2_io)
   );

   sram_board sram_board_inst (
      .pins    (pins),
      .ram1_io (ram1_io),
      .ram2_io (ram2_io)
   );

endmodule

/* tb_clock.sv */
// Free-running testbench clock with a 10 ns period, starting low.
`timescale 1ns/1ps

module tb_clock (
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk; // Half period of 5 ns.
   end

endmodule

/* sram_sys_sva.sv */
// Pin protocol assertions, bound into every sram_ctrl instance.
// Checked on rising clock edges and held off while rst is high.
`timescale 1ns/1ps

module sram_sys_sva (
   input logic                 clk,
   input logic                 rst,
   input logic                 done,
   input logic                 drive,
   input sram_pkg::sram_pins_t pins
);

   // A chip never sees its write and read strobes low at once.
   strobe_exclusive: assert property (
      @(posedge clk) disable iff (rst) pins.we_n || pins.oe_n
   ) else $error("we_n and oe_n are low in the same cycle");

   bus_turnaround: assert property (
      @(posedge clk) disable iff (rst) !pins.oe_n |-> !drive
   ) else $error("controller drives a data bus while oe_n is low");

   done_pulse: assert property (
      @(posedge clk) disable iff (rst) done |=> !done
   ) else $error("done stayed high for more than one cycle");

endmodule

bind sram_ctrl sram_sys_sva sram_sys_sva_inst (
   .clk   (clk),
   .rst   (rst),
   .done  (done),
   .drive (drive),
   .pins  (pins)
);

/* sram_sys_tb.sv */
// Table-driven testbench for the two-chip SRAM subsystem.
// Directed entries carry fixed expected values, random entries use a shadow memory.
// The shadow starts at zero, matching the board model's clear at start.
`timescale 1ns/1ps
`include "sram_params.svh"

module sram_sys_tb;

   localparam int LATENCY = `SRAM_SETUP + `SRAM_STROBE + 1;
   localparam int TIMEOUT = 20;

   typedef struct packed {
      sram_pkg::sram_req_t req;
      logic [`SRAM_DW-1:0] exp_data;
      logic                use_shadow; // Expected read value comes from the shadow.
      logic                poke;       // Raise a second req while busy.
   } entry_t;

   logic                clk;
   logic                rst;
   logic                req;
   sram_pkg::sram_req_t req_data;
   logic                busy;
   logic                done;
   logic [`SRAM_DW-1:0] rdata;

   entry_t              table_q[$];
   string               name_q[$];
   logic [`SRAM_DW-1:0] shadow [1 << `SRAM_AW];
   logic [`SRAM_DW-1:0] last_read; // Expected rdata left by the latest read.
   integer              seed;

   tb_clock clock_inst (.clk(clk));

   sram_sys sram_sys_inst (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .req_data (req_data),
      .busy     (busy),
      .done     (done),
      .rdata    (rdata)
   );

   function automatic logic [`SRAM_DW-1:0] lane_mask(input logic [3:0] be);
      logic [`SRAM_DW-1:0] m;
      m = '0;
      for (int i = 0; i < 4; i++)
      begin
         if (be[i])
         begin
            m[8*i +: 8] = 8'hff;
         end
      end
      return m;
   endfunction

   task automatic stop_run();
      $display("Verification failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_word(input string name, input logic [`SRAM_DW-1:0] exp_v,
                             input logic [`SRAM_DW-1:0] act_v);
      if (act_v !== exp_v)
      begin
         $display("** Error: %s expected %h actual %h", name, exp_v, act_v);
         stop_run();
      end
   endtask

   task automatic check_flag(input string name, input logic exp_v, input logic act_v);
      if (act_v !== exp_v)
      begin
         $display("** Error: %s expected %b actual %b", name, exp_v, act_v);
         stop_run();
      end
   endtask

   task automatic check_count(input string name, input int exp_v, input int act_v);
      if (act_v != exp_v)
      begin
         $display("** Error: %s expected %0d actual %0d", name, exp_v, act_v);
         stop_run();
      end
   endtask

   // For reads, data is the expected value. For writes, it is the write data.
   task automatic add_entry(input string name, input logic we, input logic [`SRAM_AW-1:0] addr,
                            input logic [3:0] be, input logic [`SRAM_DW-1:0] data,
                            input logic use_shadow, input logic poke);
      entry_t e;
      e.req.addr   = addr;
      e.req.we     = we;
      e.req.be     = be;
      e.req.wdata  = we ? data : '0;
      e.exp_data   = we ? '0 : data;
      e.use_shadow = use_shadow;
      e.poke       = poke;
      table_q.push_back(e);
      name_q.push_back(name);
   endtask

   task automatic build_table();
      logic [31:0] r_addr;
      logic [31:0] r_data;
      logic [31:0] r_be;
      add_entry("reset_read", 1'b0, 18'h00123, 4'hf, 32'h00000000, 1'b0, 1'b0);
      add_entry("reset_read_top", 1'b0, 18'h3ffff, 4'hf, 32'h00000000, 1'b0, 1'b0);
      add_entry("full_write", 1'b1, 18'h00010, 4'hf, 32'h11223344, 1'b0, 1'b0);
      add_entry("full_read", 1'b0, 18'h00010, 4'hf, 32'h11223344, 1'b0, 1'b0);
      add_entry("upper_write", 1'b1, 18'h00010, 4'hc, 32'haabbccdd, 1'b0, 1'b0);
      add_entry("upper_check", 1'b0, 18'h00010, 4'hf, 32'haabb3344, 1'b0, 1'b0);
      add_entry("lower_write", 1'b1, 18'h00010, 4'h3, 32'h55667788, 1'b0, 1'b0);
      add_entry("lower_check", 1'b0, 18'h00010, 4'hf, 32'haabb7788, 1'b0, 1'b0);
      add_entry("byte_write", 1'b1, 18'h00010, 4'h4, 32'h00ee0000, 1'b0, 1'b0);
      add_entry("byte_check", 1'b0, 18'h00010, 4'hf, 32'haaee7788, 1'b0, 1'b0);
      add_entry("partial_read_b31", 1'b0, 18'h00010, 4'ha, 32'haa007700, 1'b0, 1'b0);
      add_entry("partial_read_b0", 1'b0, 18'h00010, 4'h1, 32'h00000088, 1'b0, 1'b0);
      add_entry("busy_write", 1'b1, 18'h00200, 4'hf, 32'hcafe0001, 1'b0, 1'b1);
      add_entry("busy_check", 1'b0, 18'h00200, 4'hf, 32'hcafe0001, 1'b0, 1'b0);
      for (int i = 0; i < 20; i++)
      begin
         r_addr = $random(seed);
         r_data = $random(seed);
         r_be   = $random(seed);
         if (i == 0)
         begin
            r_addr = 32'h00000000;
         end
         if (i == 1)
         begin
            r_addr = 32'h0003ffff; // Top word of the address range.
         end
         add_entry($sformatf("random_write_%0d", i), 1'b1, r_addr[`SRAM_AW-1:0], r_be[3:0],
                   r_data, 1'b0, 1'b0);
         r_be = $random(seed);
         add_entry($sformatf("random_read_%0d", i), 1'b0, r_addr[`SRAM_AW-1:0], r_be[3:0],
                   32'h00000000, 1'b1, 1'b0);
      end
   endtask

   task automatic update_shadow(input sram_pkg::sram_req_t r);
      logic [`SRAM_DW-1:0] m;
      m = lane_mask(r.be);
      shadow[r.addr] = (shadow[r.addr] & ~m) | (r.wdata & m);
   endtask

   task automatic run_access(input string name, input entry_t e);
      logic [`SRAM_DW-1:0] exp_v;
      sram_pkg::sram_req_t extra;
      int                  n;
      exp_v = e.use_shadow ? (shadow[e.req.addr] & lane_mask(e.req.be)) : e.exp_data;
      extra = e.req;
      extra.wdata = 32'hdeadbeef;
      check_flag({name, " idle before request"}, 1'b0, busy);
      @(posedge clk);
      req      <= 1'b1;
      req_data <= e.req;
      @(posedge clk);
      req <= 1'b0; // Accepted on this edge.
      @(negedge clk);
      check_flag({name, " busy after accept"}, 1'b1, busy);
      n = 0;
      while (!done)
      begin
         @(posedge clk);
         n++;
         if (e.poke)
         begin
            req      <= (n == 1);
            req_data <= extra;
         end
         @(negedge clk);
         if (n > TIMEOUT)
         begin
            $display("Timeout in %s: done never arrived after %0d cycles", name, TIMEOUT);
            stop_run();
         end
      end
      check_count({name, " latency"}, LATENCY, n);
      check_flag({name, " busy at done"}, 1'b0, busy);
      check_word(name, e.req.we ? last_read : exp_v, rdata);
      if (e.req.we)
      begin
         update_shadow(e.req);
      end
      else
      begin
         last_read = exp_v;
      end
      if (e.poke)
      begin
         for (int i = 0; i < 2 * LATENCY; i++)
         begin
            @(negedge clk);
            check_flag({name, " no second done"}, 1'b0, done);
            check_flag({name, " stays idle"}, 1'b0, busy);
         end
      end
   endtask

   initial
   begin
      rst       = 1'b1;
      req       = 1'b0;
      req_data  = '0;
      last_read = '0;
      seed      = 32'h6da7;
      for (int i = 0; i < (1 << `SRAM_AW); i++)
      begin
         shadow[i] = '0;
      end
      build_table();
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_flag("reset busy", 1'b0, busy);
      check_flag("reset done", 1'b0, done);
      for (int i = 0; i < table_q.size(); i++)
      begin
         run_access(name_q[i], table_q[i]);
      end
      $display("Verification passed");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+.
sram_pkg.sv
sram_chip.sv
sram_board.sv
sram_ctrl.sv
sram_sys.sv
tb_clock.sv
sram_sys_sva.sv
sram_sys_tb.sv

/* run.sh */
#!/bin/sh
# Builds and runs the SRAM subsystem testbench with Verilator.
# The exit status of the simulation is the result of the run.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
   --top-module sram_sys_tb -o sram_sys_tb
./obj_dir/sram_sys_tb
